// File: hw/tio_hk_pkg.sv
`default_nettype none

package tio_hk_pkg;

    // Wishbone request as driven by the bus master
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [11:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    // Wishbone response from the target
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Register byte offsets
    localparam logic [11:0] ADR_DEVICE      = 12'h000;
    localparam logic [11:0] ADR_VERSION     = 12'h004;
    localparam logic [11:0] ADR_ID_LO       = 12'h008;
    localparam logic [11:0] ADR_CTRLSTAT    = 12'h00C;
    localparam logic [11:0] ADR_SYNC        = 12'h010;
    localparam logic [11:0] ADR_CLKOFF      = 12'h014;
    localparam logic [11:0] ADR_ID_HI       = 12'h018;
    // Clock monitor window, one word per clock
    localparam logic [11:0] ADR_CLKMON_BASE = 12'h040;

    // Serial ID length in bits
    localparam int ID_BITS = 57;

    // Monitor window holds this many slots
    localparam int MAX_CLOCKS = 8;
    // Divider in each monitored domain, counts by 2**CLK_DIV_BITS
    localparam int CLK_DIV_BITS = 3;
    // Latched edge count width
    localparam int CNT_WIDTH = 16;
    // Fewer edges than this in a window means the clock is stopped
    localparam int RUN_MIN_EDGES = 2;

    // Monitor slots that feed the ok flags
    localparam int CLK_IDX_SYS = 0;
    localparam int CLK_IDX_RX  = 2;

endpackage

`default_nettype wire

// File: hw/clock_mon_timer.sv
`timescale 1ns/1ns
`default_nettype none

module clock_mon_timer import tio_hk_pkg::*; #(
    parameter int GATE_CYCLES = 256
) (
    input  wire logic wb_clk_i,
    input  wire logic wb_rst_i,
    output      logic gate_end_o
);

    localparam int TMR_W = $clog2(GATE_CYCLES);

    logic [TMR_W-1:0] tmr_q;

    // Free running down counter, one window per GATE_CYCLES clocks
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            tmr_q      <= TMR_W'(GATE_CYCLES - 1);
            gate_end_o <= 1'b0;
        end else if (tmr_q == '0) begin
            // Window ends, start the next one
            tmr_q      <= TMR_W'(GATE_CYCLES - 1);
            gate_end_o <= 1'b1;
        end else begin
            tmr_q      <= tmr_q - 1'b1;
            gate_end_o <= 1'b0;
        end
    end

    // Counters latch on a single cycle pulse
    a_gate_pulse: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        gate_end_o |=> !gate_end_o
    );

endmodule

`default_nettype wire

// File: hw/clock_mon_counter.sv
`timescale 1ns/1ns
`default_nettype none

module clock_mon_counter import tio_hk_pkg::*; (
    input  wire logic                 wb_clk_i,
    input  wire logic                 wb_rst_i,
    input  wire logic                 mon_clk_i,
    input  wire logic                 gate_end_i,
    output      logic [CNT_WIDTH-1:0] count_o,
    output      logic                 running_o
);

    logic [1:0]              mon_rst_q;
    logic [CLK_DIV_BITS-1:0] div_q;
    logic [1:0]              sync_q;
    logic                    msb_prev_q;
    logic                    rise;
    logic [CNT_WIDTH-1:0]    live_q;

    // Reset carried into the monitored domain
    always_ff @(posedge mon_clk_i) begin
        mon_rst_q <= {mon_rst_q[0], wb_rst_i};
    end

    // Divider slows the monitored clock below wb sampling rate
    always_ff @(posedge mon_clk_i) begin
        if (mon_rst_q[1]) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    // Two flop synchronizer on the divider MSB
    always_ff @(posedge wb_clk_i) begin
        sync_q <= {sync_q[0], div_q[CLK_DIV_BITS-1]};
    end

    assign rise = sync_q[1] & ~msb_prev_q;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            msb_prev_q <= 1'b0;
            live_q     <= '0;
            count_o    <= '0;
            running_o  <= 1'b0;
        end else begin
            msb_prev_q <= sync_q[1];
            if (gate_end_i) begin
                // Latch result and restart, keeping an edge seen this cycle
                count_o   <= live_q;
                running_o <= (live_q >= CNT_WIDTH'(RUN_MIN_EDGES));
                live_q    <= CNT_WIDTH'(rise);
            end else if (rise && (live_q != '1)) begin
                // Saturate at all ones
                live_q <= live_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/serial_id_reader.sv
`timescale 1ns/1ns
`default_nettype none

module serial_id_reader import tio_hk_pkg::*; (
    input  wire logic               wb_clk_i,
    input  wire logic               wb_rst_i,
    input  wire logic               reload_i,
    input  wire logic               id_dat_i,
    output      logic               id_read_o,
    output      logic               id_shift_o,
    output      logic [ID_BITS-1:0] id_value_o,
    output      logic               id_valid_o
);

    localparam int BIT_CNT_W = $clog2(ID_BITS);

    // IDLE only waits one cycle after reset before the first readout
    typedef enum logic [1:0] {
        IDLE,
        READ,
        SHIFT,
        DONE
    } state_t;

    state_t               state_q;
    logic [BIT_CNT_W-1:0] bit_cnt_q;

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q    <= IDLE;
            bit_cnt_q  <= '0;
            id_valid_o <= 1'b0;
        end else if (reload_i) begin
            // Reload restarts from any state
            state_q    <= READ;
            bit_cnt_q  <= '0;
            id_valid_o <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    state_q <= READ;
                end
                READ: begin
                    // Port loads its value here and shows the MSB
                    state_q   <= SHIFT;
                    bit_cnt_q <= '0;
                end
                SHIFT: begin
                    if (bit_cnt_q == BIT_CNT_W'(ID_BITS - 1)) begin
                        state_q    <= DONE;
                        id_valid_o <= 1'b1;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                DONE: begin
                    state_q <= DONE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Serial value fills MSB first with one bit per shift cycle
    always_ff @(posedge wb_clk_i) begin
        if (state_q == SHIFT) begin
            id_value_o <= {id_value_o[ID_BITS-2:0], id_dat_i};
        end
    end

    // Port strobes decoded from state
    assign id_read_o  = (state_q == READ);
    assign id_shift_o = (state_q == SHIFT);

    // A held reload would pin the FSM in READ and starve the port of shifts
    a_reload_pulse: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        reload_i |=> !reload_i
    );

endmodule

`default_nettype wire

// File: hw/tio_id_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tio_id_ctrl import tio_hk_pkg::*; #(
    parameter logic [31:0] DEVICE     = "TFIO",
    parameter logic [31:0] VERSION    = 32'h0000_0000,
    parameter int          NUM_CLOCKS = 6
) (
    input  wire logic                             wb_clk_i,
    input  wire logic                             wb_rst_i,
    input  wire wb_req_t                          wb_req_i,
    output      wb_rsp_t                          wb_rsp_o,
    input  wire logic [1:0]                       crate_conf_i,
    input  wire logic                             i2c_rdy_i,
    input  wire logic [ID_BITS-1:0]               id_value_i,
    input  wire logic                             id_valid_i,
    input  wire logic [NUM_CLOCKS*CNT_WIDTH-1:0]  clk_count_i,
    input  wire logic [NUM_CLOCKS-1:0]            clk_running_i,
    output      logic                             id_reload_o,
    output      logic [7:0]                       sync_offset_o,
    output      logic                             en_ext_sync_o,
    output      logic [7:0]                       clk_offset_o,
    output      logic                             enable_crate_o,
    output      logic                             enable_3v3_o,
    output      logic                             sys_clk_ok_o,
    output      logic                             rx_clk_ok_o
);

    // Address bits that pick a monitor slot
    localparam int SLOT_BITS = $clog2(MAX_CLOCKS);

    logic                             ack_q;
    logic                             wr_ack;
    logic [8:0]                       sync_reg;
    logic [7:0]                       clk_off_reg;
    logic                             en_crate_q;
    logic                             en_3v3_q;
    logic [1:0]                       crate_conf_q;
    logic                             i2c_rdy_q;
    logic [31:0]                      ctrlstat;
    logic [31:0]                      rd_dat;
    logic                             mon_hit;
    logic [SLOT_BITS-1:0]             slot;
    // Monitor inputs padded to the full window so absent slots read zero
    logic [MAX_CLOCKS*CNT_WIDTH-1:0]  count_all;
    logic [MAX_CLOCKS-1:0]            running_all;

    assign count_all   = (MAX_CLOCKS*CNT_WIDTH)'(clk_count_i);
    assign running_all = MAX_CLOCKS'(clk_running_i);

    // Monitor window 0x040..0x05C
    assign mon_hit = (wb_req_i.adr[11:SLOT_BITS+2] == ADR_CLKMON_BASE[11:SLOT_BITS+2]);
    assign slot    = wb_req_i.adr[SLOT_BITS+1:2];

    // Single pulse ack one cycle after the strobe is seen
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_req_i.cyc & wb_req_i.stb & ~ack_q;
        end
    end

    // Write effects land on the ack cycle
    assign wr_ack = ack_q & wb_req_i.cyc & wb_req_i.stb & wb_req_i.we;

    // Writable control registers
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            sync_reg    <= '0;
            clk_off_reg <= '0;
            en_crate_q  <= 1'b1;
            en_3v3_q    <= 1'b1;
        end else if (wr_ack) begin
            case (wb_req_i.adr)
                ADR_SYNC: sync_reg <= wb_req_i.dat[8:0];
                ADR_CLKOFF: clk_off_reg <= wb_req_i.dat[7:0];
                ADR_CTRLSTAT: begin
                    // Enables live in the low byte
                    if (wb_req_i.sel[0]) begin
                        en_crate_q <= wb_req_i.dat[2];
                        en_3v3_q   <= wb_req_i.dat[3];
                    end
                end
                default: ;
            endcase
        end
    end

    // Board inputs registered once
    always_ff @(posedge wb_clk_i) begin
        crate_conf_q <= crate_conf_i;
        i2c_rdy_q    <= i2c_rdy_i;
    end

    // Reload command is bit 31 in the top byte
    assign id_reload_o = wr_ack && (wb_req_i.adr == ADR_CTRLSTAT)
                         && wb_req_i.sel[3] && wb_req_i.dat[31];

    assign sys_clk_ok_o = running_all[CLK_IDX_SYS];
    assign rx_clk_ok_o  = running_all[CLK_IDX_RX];

    // Status/control word
    always_comb begin
        ctrlstat      = '0;
        ctrlstat[0]   = sys_clk_ok_o;
        ctrlstat[1]   = rx_clk_ok_o;
        ctrlstat[2]   = en_crate_q;
        ctrlstat[3]   = en_3v3_q;
        ctrlstat[4]   = i2c_rdy_q;
        ctrlstat[9:8] = crate_conf_q;
        ctrlstat[16]  = id_valid_i;
    end

    // Read mux output is valid while ack is high
    always_comb begin
        rd_dat = '0;
        if (mon_hit) begin
            rd_dat = 32'(count_all[slot*CNT_WIDTH +: CNT_WIDTH]);
        end else begin
            case (wb_req_i.adr)
                ADR_DEVICE:   rd_dat = DEVICE;
                ADR_VERSION:  rd_dat = VERSION;
                ADR_ID_LO:    rd_dat = id_value_i[31:0];
                ADR_CTRLSTAT: rd_dat = ctrlstat;
                ADR_SYNC:     rd_dat = 32'(sync_reg);
                ADR_CLKOFF:   rd_dat = 32'(clk_off_reg);
                // Upper serial bits right aligned
                ADR_ID_HI:    rd_dat = 32'(id_value_i[ID_BITS-1:32]);
                default:      rd_dat = '0;
            endcase
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_dat;

    assign sync_offset_o  = sync_reg[7:0];
    assign en_ext_sync_o  = sync_reg[8];
    assign clk_offset_o   = clk_off_reg;
    assign enable_crate_o = en_crate_q;
    assign enable_3v3_o   = en_3v3_q;

    // Master keeps the request up through the ack cycle
    a_ack_in_cycle: assert property (
        @(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb)
    );

endmodule

`default_nettype wire

// File: hw/tio_hk_top.sv
`timescale 1ns/1ns
`default_nettype none

module tio_hk_top import tio_hk_pkg::*; #(
    parameter logic [31:0] DEVICE      = "TFIO",
    parameter logic [31:0] VERSION     = 32'h0001_0000,
    parameter int          NUM_CLOCKS  = 6,
    parameter int          GATE_CYCLES = 256
) (
    input  wire logic                  wb_clk_i,
    input  wire logic                  wb_rst_i,
    input  wire logic                  wb_cyc_i,
    input  wire logic                  wb_stb_i,
    input  wire logic                  wb_we_i,
    input  wire logic [11:0]           wb_adr_i,
    input  wire logic [31:0]           wb_dat_i,
    input  wire logic [3:0]            wb_sel_i,
    output      logic                  wb_ack_o,
    output      logic [31:0]           wb_dat_o,
    input  wire logic [1:0]            crate_conf_i,
    input  wire logic                  i2c_rdy_i,
    input  wire logic [NUM_CLOCKS-1:0] mon_clk_i,
    input  wire logic                  id_dat_i,
    output      logic [7:0]            sync_offset_o,
    output      logic                  en_ext_sync_o,
    output      logic [7:0]            clk_offset_o,
    output      logic                  enable_crate_o,
    output      logic                  enable_3v3_o,
    output      logic                  sys_clk_ok_o,
    output      logic                  rx_clk_ok_o,
    output      logic                  id_read_o,
    output      logic                  id_shift_o
);

    wb_req_t                         wb_req;
    wb_rsp_t                         wb_rsp;
    logic                            id_reload;
    logic [ID_BITS-1:0]              id_value;
    logic                            id_valid;
    logic                            gate_end;
    logic [NUM_CLOCKS*CNT_WIDTH-1:0] clk_count;
    logic [NUM_CLOCKS-1:0]           clk_running;

    // Bus ports gathered into the request struct
    assign wb_req = '{cyc: wb_cyc_i, stb: wb_stb_i, we: wb_we_i,
                      adr: wb_adr_i, dat: wb_dat_i, sel: wb_sel_i};

    assign wb_ack_o = wb_rsp.ack;
    assign wb_dat_o = wb_rsp.dat;

    tio_id_ctrl #(
        .DEVICE     (DEVICE),
        .VERSION    (VERSION),
        .NUM_CLOCKS (NUM_CLOCKS)
    ) u_ctrl (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wb_req_i       (wb_req),
        .wb_rsp_o       (wb_rsp),
        .crate_conf_i   (crate_conf_i),
        .i2c_rdy_i      (i2c_rdy_i),
        .id_value_i     (id_value),
        .id_valid_i     (id_valid),
        .clk_count_i    (clk_count),
        .clk_running_i  (clk_running),
        .id_reload_o    (id_reload),
        .sync_offset_o  (sync_offset_o),
        .en_ext_sync_o  (en_ext_sync_o),
        .clk_offset_o   (clk_offset_o),
        .enable_crate_o (enable_crate_o),
        .enable_3v3_o   (enable_3v3_o),
        .sys_clk_ok_o   (sys_clk_ok_o),
        .rx_clk_ok_o    (rx_clk_ok_o)
    );

    // Shared window for all monitors
    clock_mon_timer #(
        .GATE_CYCLES (GATE_CYCLES)
    ) u_timer (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .gate_end_o (gate_end)
    );

    // One counter per monitored clock
    for (genvar i = 0; i < NUM_CLOCKS; i++) begin : g_mon
        clock_mon_counter u_cnt (
            .wb_clk_i   (wb_clk_i),
            .wb_rst_i   (wb_rst_i),
            .mon_clk_i  (mon_clk_i[i]),
            .gate_end_i (gate_end),
            .count_o    (clk_count[i*CNT_WIDTH +: CNT_WIDTH]),
            .running_o  (clk_running[i])
        );
    end

    serial_id_reader u_id (
        .wb_clk_i   (wb_clk_i),
        .wb_rst_i   (wb_rst_i),
        .reload_i   (id_reload),
        .id_dat_i   (id_dat_i),
        .id_read_o  (id_read_o),
        .id_shift_o (id_shift_o),
        .id_value_o (id_value),
        .id_valid_o (id_valid)
    );

endmodule

`default_nettype wire

// File: test/tb_tio_hk_tasks.svh
`ifndef TB_TIO_HK_TASKS_SVH
`define TB_TIO_HK_TASKS_SVH

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: FAILED with %0d errors", tests_run, name,
                     errors - err_start);
        end
    endtask

    // New serial ID for the port model
    task automatic draw_id();
        logic [63:0] r;
        r        = {$random(seed), $random(seed)};
        id_model = r[ID_BITS-1:0];
    endtask

    // One Wishbone transfer, held through the ack edge
    task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                             input logic [3:0] sel, output logic [31:0] rdat);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        rdat   = '0;
        @(negedge wb_clk_i);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        wb_sel   = sel;
        while (!seen && waited < ACK_LIMIT) begin
            @(negedge wb_clk_i);
            waited++;
            if (wb_ack) begin
                seen = 1'b1;
                rdat = wb_dat_r;
            end
        end
        if (!seen) begin
            $display("no acknowledge from the DUT for address 0x%03h within %0d cycles",
                     adr, ACK_LIMIT);
            errors++;
        end
        // Write lands on the edge that ends the ack cycle
        @(negedge wb_clk_i);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [11:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, sel, unused);
    endtask

    task automatic bus_read(input logic [11:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'h0, 4'hF, dat);
    endtask

    // Read and compare the masked word
    task automatic read_check(input logic [11:0] adr, input logic [31:0] mask,
                              input logic [31:0] exp, input string name);
        logic [31:0] rd;
        bus_read(adr, rd);
        check_val(name, rd & mask, exp);
    endtask

    task automatic wait_id_valid();
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[16] && polls < ID_POLL_LIMIT) begin
            bus_read(ADR_CTRLSTAT, st);
            polls++;
        end
        if (!st[16]) begin
            $display("serial ID did not become valid after %0d status reads", polls);
            errors++;
        end
    endtask

    function automatic int mon_period(input int idx);
        case (idx)
            3, 5:    return MON_P_FAST;
            4:       return MON_P_MID;
            default: return MON_P_SLOW;
        endcase
    endfunction

    // Count must sit within 2 of the nominal edges per window
    task automatic check_count(input int idx, input logic [31:0] got);
        int expv;
        int near;
        expv = GATE * CLK_PERIOD / ((1 << CLK_DIV_BITS) * mon_period(idx));
        // Nearest edge of the tolerance band
        if (int'(got) < expv - 2) begin
            near = expv - 2;
        end else if (int'(got) > expv + 2) begin
            near = expv + 2;
        end else begin
            near = int'(got);
        end
        check_val($sformatf("clk_count[%0d]", idx), got, 32'(near));
    endtask

    task automatic test_reset_identity();
        int e0;
        e0 = errors;
        // No rising edge since reset release yet
        check_val("sync_offset_o", 32'(sync_offset), 32'h0);
        check_val("en_ext_sync_o", 32'(en_ext_sync), 32'h0);
        check_val("clk_offset_o", 32'(clk_offset), 32'h0);
        check_val("enable_crate_o", 32'(enable_crate), 32'h1);
        check_val("enable_3v3_o", 32'(enable_3v3), 32'h1);
        check_val("wb_ack_o", 32'(wb_ack), 32'h0);
        check_val("id_read_o", 32'(id_read), 32'h0);
        check_val("id_shift_o", 32'(id_shift), 32'h0);
        check_val("sys_clk_ok_o", 32'(sys_clk_ok), 32'h0);
        check_val("rx_clk_ok_o", 32'(rx_clk_ok), 32'h0);
        read_check(ADR_DEVICE, '1, DEVICE_WORD, "device");
        read_check(ADR_VERSION, '1, VERSION_WORD, "version");
        // Enables set, no flags, serial readout still running
        read_check(ADR_CTRLSTAT, '1, 32'h0000_000C, "ctrlstat");
        read_check(ADR_SYNC, '1, 32'h0, "sync");
        read_check(ADR_CLKOFF, '1, 32'h0, "clkoff");
        finish_test("reset and identity", e0);
    endtask

    task automatic test_control_regs();
        int e0;
        e0 = errors;
        bus_write(ADR_SYNC, 32'hFFFF_F1A5, 4'hF);
        bus_write(ADR_CLKOFF, 32'h1234_5678, 4'hF);
        check_val("sync_offset_o", 32'(sync_offset), 32'h0000_00A5);
        check_val("en_ext_sync_o", 32'(en_ext_sync), 32'h1);
        check_val("clk_offset_o", 32'(clk_offset), 32'h0000_0078);
        read_check(ADR_SYNC, '1, 32'h0000_01A5, "sync");
        read_check(ADR_CLKOFF, '1, 32'h0000_0078, "clkoff");
        // Enables follow the low byte only
        bus_write(ADR_CTRLSTAT, 32'h0, 4'b0001);
        check_val("enable_crate_o", 32'(enable_crate), 32'h0);
        check_val("enable_3v3_o", 32'(enable_3v3), 32'h0);
        bus_write(ADR_CTRLSTAT, 32'h0000_000C, 4'b1110);
        check_val("enable_crate_o", 32'(enable_crate), 32'h0);
        check_val("enable_3v3_o", 32'(enable_3v3), 32'h0);
        read_check(ADR_CTRLSTAT, 32'h0000_000C, 32'h0, "ctrlstat enables");
        bus_write(ADR_CTRLSTAT, 32'h0000_000C, 4'b0001);
        check_val("enable_crate_o", 32'(enable_crate), 32'h1);
        check_val("enable_3v3_o", 32'(enable_3v3), 32'h1);
        // Board inputs pass one register stage
        crate_conf = 2'b10;
        i2c_rdy    = 1'b1;
        repeat (2) @(negedge wb_clk_i);
        read_check(ADR_CTRLSTAT, 32'h0000_031C, 32'h0000_021C, "ctrlstat inputs");
        bus_write(12'h020, 32'hDEAD_BEEF, 4'hF);
        read_check(12'h01C, '1, 32'h0, "unused 0x01C");
        read_check(12'h020, '1, 32'h0, "unused 0x020");
        read_check(12'h03C, '1, 32'h0, "unused 0x03C");
        read_check(12'h060, '1, 32'h0, "unused 0x060");
        finish_test("control registers", e0);
    endtask

    task automatic test_serial_id();
        int e0;
        e0 = errors;
        wait_id_valid();
        read_check(ADR_ID_LO, '1, id_model[31:0], "id_lo");
        read_check(ADR_ID_HI, '1, 32'(id_model[ID_BITS-1:32]), "id_hi");
        draw_id();
        // Reload command sits in the top byte
        bus_write(ADR_CTRLSTAT, 32'h8000_0000, 4'b1000);
        read_check(ADR_CTRLSTAT, 32'h0001_000C, 32'h0000_000C, "ctrlstat after reload");
        wait_id_valid();
        read_check(ADR_ID_LO, '1, id_model[31:0], "id_lo reloaded");
        read_check(ADR_ID_HI, '1, 32'(id_model[ID_BITS-1:32]), "id_hi reloaded");
        finish_test("serial id", e0);
    endtask

    task automatic test_clock_monitors();
        int          e0;
        logic [31:0] rd;
        e0 = errors;
        repeat (WINDOW_WAIT) @(negedge wb_clk_i);
        for (int i = 0; i < MAX_CLOCKS; i++) begin
            bus_read(ADR_CLKMON_BASE + 12'(4 * i), rd);
            if (i < NUM_CLK) begin
                check_count(i, rd);
            end else begin
                check_val($sformatf("clk_count[%0d]", i), rd, 32'h0);
            end
        end
        check_val("sys_clk_ok_o", 32'(sys_clk_ok), 32'h1);
        check_val("rx_clk_ok_o", 32'(rx_clk_ok), 32'h1);
        read_check(ADR_CTRLSTAT, 32'h0000_0003, 32'h0000_0003, "ctrlstat ok bits");
        finish_test("clock monitors", e0);
    endtask

    task automatic test_stopped_clock();
        int e0;
        e0 = errors;
        clk2_run = 1'b0;
        // One partial window, then a full one without edges
        repeat (WINDOW_WAIT) @(negedge wb_clk_i);
        read_check(ADR_CLKMON_BASE + 12'(4 * CLK_IDX_RX), '1, 32'h0, "clk_count[2]");
        check_val("rx_clk_ok_o", 32'(rx_clk_ok), 32'h0);
        check_val("sys_clk_ok_o", 32'(sys_clk_ok), 32'h1);
        read_check(ADR_CTRLSTAT, 32'h0000_0003, 32'h0000_0001, "ctrlstat ok bits");
        finish_test("stopped clock", e0);
    endtask

`endif

// File: test/tb_tio_hk.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tio_hk
    import tio_hk_pkg::*;
();

    // Values the DUT is built with
    localparam logic [31:0] DEVICE_WORD  = "TFIO";
    localparam logic [31:0] VERSION_WORD = 32'h0001_0000;
    localparam int          NUM_CLK      = 6;
    localparam int          GATE         = 256;
    localparam int          CLK_PERIOD   = 10;

    // Monitored clock periods in ns
    localparam int MON_P_SLOW = 8;
    localparam int MON_P_MID  = 5;
    localparam int MON_P_FAST = 4;

    // Bus access budget in wb cycles
    localparam int ACK_LIMIT     = 16;
    localparam int ACCESS_MAX    = ACK_LIMIT + 2;
    localparam int ID_POLL_LIMIT = 40;
    // Two full gate windows plus latch latency
    localparam int WINDOW_WAIT   = 2 * GATE + 8;

    // Test lengths in wb cycles, worst case
    localparam int T1_CYCLES   = 8 * ACCESS_MAX;
    localparam int T2_CYCLES   = 20 * ACCESS_MAX + 4;
    localparam int T3_CYCLES   = (2 * ID_POLL_LIMIT + 6) * ACCESS_MAX;
    localparam int T4_CYCLES   = WINDOW_WAIT + 10 * ACCESS_MAX;
    localparam int T5_CYCLES   = WINDOW_WAIT + 4 * ACCESS_MAX;
    localparam int RUN_CYCLES  = 5 + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES;
    localparam int WATCHDOG_NS = (RUN_CYCLES + 200) * CLK_PERIOD;

    logic               wb_clk_i = 1'b0;
    logic               wb_rst_i;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [11:0]        wb_adr;
    logic [31:0]        wb_dat_w;
    logic [3:0]         wb_sel;
    logic               wb_ack;
    logic [31:0]        wb_dat_r;
    logic [1:0]         crate_conf;
    logic               i2c_rdy;
    logic [NUM_CLK-1:0] mon_clk;
    logic               id_dat;
    logic [7:0]         sync_offset;
    logic               en_ext_sync;
    logic [7:0]         clk_offset;
    logic               enable_crate;
    logic               enable_3v3;
    logic               sys_clk_ok;
    logic               rx_clk_ok;
    logic               id_read;
    logic               id_shift;

    // Monitored clock sources, index 2 can be stopped
    logic mclk0 = 1'b0;
    logic mclk1 = 1'b0;
    logic mclk2 = 1'b0;
    logic mclk3 = 1'b0;
    logic mclk4 = 1'b0;
    logic mclk5 = 1'b0;
    logic clk2_run;

    // Serial ID port model
    logic [ID_BITS-1:0] id_model;
    logic [ID_BITS-1:0] id_shreg = '0;
    logic               shift_seen = 1'b0;

    integer seed;
    int     errors;
    int     checks;
    int     tests_run;

    always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

    always #(MON_P_SLOW / 2) mclk0 = ~mclk0;
    always #(MON_P_SLOW / 2) mclk1 = ~mclk1;
    always begin
        #(MON_P_SLOW / 2);
        mclk2 = clk2_run ? ~mclk2 : 1'b0;
    end
    always #(MON_P_FAST / 2) mclk3 = ~mclk3;
    // 5 ns period, uneven duty on a 1 ns grid
    always begin
        #3;
        mclk4 = 1'b1;
        #2;
        mclk4 = 1'b0;
    end
    always #(MON_P_FAST / 2) mclk5 = ~mclk5;

    assign mon_clk = {mclk5, mclk4, mclk3, mclk2, mclk1, mclk0};

    // Load on read, show MSB; after each consumed shift the next bit appears
    assign id_dat = id_shreg[ID_BITS-1];

    always @(negedge wb_clk_i) begin
        if (id_read) begin
            id_shreg   <= id_model;
            shift_seen <= 1'b0;
        end else begin
            if (shift_seen) begin
                id_shreg <= {id_shreg[ID_BITS-2:0], 1'b0};
            end
            shift_seen <= id_shift;
        end
    end

    tio_hk_top #(
        .DEVICE      (DEVICE_WORD),
        .VERSION     (VERSION_WORD),
        .NUM_CLOCKS  (NUM_CLK),
        .GATE_CYCLES (GATE)
    ) dut (
        .wb_clk_i       (wb_clk_i),
        .wb_rst_i       (wb_rst_i),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat_w),
        .wb_sel_i       (wb_sel),
        .wb_ack_o       (wb_ack),
        .wb_dat_o       (wb_dat_r),
        .crate_conf_i   (crate_conf),
        .i2c_rdy_i      (i2c_rdy),
        .mon_clk_i      (mon_clk),
        .id_dat_i       (id_dat),
        .sync_offset_o  (sync_offset),
        .en_ext_sync_o  (en_ext_sync),
        .clk_offset_o   (clk_offset),
        .enable_crate_o (enable_crate),
        .enable_3v3_o   (enable_3v3),
        .sys_clk_ok_o   (sys_clk_ok),
        .rx_clk_ok_o    (rx_clk_ok),
        .id_read_o      (id_read),
        .id_shift_o     (id_shift)
    );

`include "tb_tio_hk_tasks.svh"

    // Ends a stuck run
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not complete", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

    initial begin
        wb_rst_i   = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_sel     = '0;
        crate_conf = 2'b00;
        i2c_rdy    = 1'b0;
        clk2_run   = 1'b1;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        seed       = 32'he850;
        draw_id();

        // Reset for 5 cycles, released on a falling edge
        repeat (5) @(negedge wb_clk_i);
        wb_rst_i = 1'b0;

        test_reset_identity();
        test_control_regs();
        test_serial_id();
        test_clock_monitors();
        test_stopped_clock();

        $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tio_hk.f
+incdir+test
hw/tio_hk_pkg.sv
hw/clock_mon_timer.sv
hw/clock_mon_counter.sv
hw/serial_id_reader.sv
hw/tio_id_ctrl.sv
hw/tio_hk_top.sv
test/tb_tio_hk.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_tio_hk \
    -f tio_hk.f -o tb_tio_hk \
    && ./obj_dir/tb_tio_hk | tee /dev/stderr | grep -x 'sim passed' > /dev/null \
    && echo "run_sim: PASS" \
    || { echo "run_sim: FAIL"; exit 1; }
